//--- tb.f
design/cam_log_pkg.sv
design/line_event_counter.sv
design/log_fifo.sv
design/cam_ctrl_regs.sv
design/cam_line_logger.sv
tb/cam_line_logger_asserts.sv
tb/tb_cam_line_logger.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_cam_line_logger -f tb.f -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"

echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1

//--- tb/tb_cam_line_logger.sv
module tb_cam_line_logger
    import cam_log_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_FRAMES = 8;
    // worst frame is 6 lines of 8 beats with 2 idle slots per beat plus 8 reads and 4 idle cycles
    localparam int FRAME_CYCLES = 6 * 8 * 3 + 8 * 3 + 4;
    // other tests stay well under 800 cycles
    localparam int STIM_CYCLES  = NUM_FRAMES * FRAME_CYCLES + 800;

    logic        axi4s_cam_aclk;
    logic        sys_reset;
    video_beat_t beat;
    reg_req_t    req;
    reg_rsp_t    rsp;
    logic        cam_enable;
    logic [7:0]  csi_data_type;
    logic [2:0]  fmt_select;

    int seed   = 18799;
    int checks = 0;
    int errors = 0;

    reg_addr_e ctrl_addrs[4] = '{REG_SW_RESET, REG_CAM_ENABLE, REG_DATA_TYPE, REG_FMT_SELECT};

    // --------------------
    // reference model
    // --------------------

    logic        m_sw_reset;
    logic        m_cam_enable;
    logic [7:0]  m_data_type;
    logic [2:0]  m_fmt_select;
    logic        m_first_beat;
    logic [15:0] m_line_index;
    logic [7:0]  m_frame_count;
    logic        m_overflow;
    log_entry_t  model_q[$];

    cam_line_logger uut (
        .axi4s_cam_aclk  (axi4s_cam_aclk),
        .sys_reset       (sys_reset),
        .beat_i          (beat),
        .req_i           (req),
        .rsp_o           (rsp),
        .cam_enable_o    (cam_enable),
        .csi_data_type_o (csi_data_type),
        .fmt_select_o    (fmt_select)
    );

    initial begin
        axi4s_cam_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) axi4s_cam_aclk = ~axi4s_cam_aclk;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic reg_req_t idle_req();
        reg_req_t r;
        r.wr    = 1'b0;
        r.rd    = 1'b0;
        r.addr  = REG_ID;
        r.wdata = '0;
        return r;
    endfunction

    function automatic void reset_model_log();
        m_first_beat  = 1'b1;
        m_line_index  = '0;
        m_frame_count = '0;
        m_overflow    = 1'b0;
        model_q.delete();
    endfunction

    // line and frame rules for one valid beat
    function automatic void model_beat(input logic fs, input logic le);
        log_entry_t e;
        if (m_sw_reset) begin
            return;
        end
        if (fs) begin
            m_frame_count = m_frame_count + 8'd1;
        end
        if (m_first_beat) begin
            m_line_index  = fs ? 16'd0 : m_line_index + 16'd1;
            e.frame_count = m_frame_count;
            e.line_index  = m_line_index;
            if (model_q.size() < LOG_DEPTH) begin
                model_q.push_back(e);
            end else begin
                m_overflow = 1'b1;
            end
        end
        m_first_beat = le;
    endfunction

    function automatic logic [31:0] status_expected();
        logic [31:0] w;
        w                     = '0;
        w[LOG_COUNT_BITS-1:0] = LOG_COUNT_BITS'(model_q.size());
        w[8]                  = (model_q.size() == 0);
        w[16]                 = m_overflow;
        return w;
    endfunction

    function automatic logic [31:0] expected_reg(input reg_addr_e addr);
        case (addr)
            REG_ID:         return ID_VALUE;
            REG_SW_RESET:   return 32'(m_sw_reset);
            REG_CAM_ENABLE: return 32'(m_cam_enable);
            REG_DATA_TYPE:  return 32'(m_data_type);
            REG_FMT_SELECT: return 32'(m_fmt_select);
            REG_LOG_STATUS: return status_expected();
            default:        return 32'd0;
        endcase
    endfunction

    // --------------------
    // bus and stream tasks
    // --------------------

    task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
                                 input string what);
        checks++;
        assert (got === expected) else begin
            $display("ERROR at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
        reg_req_t r;
        r       = idle_req();
        r.wr    = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        @(posedge axi4s_cam_aclk);
        req <= r;
        @(posedge axi4s_cam_aclk);
        req <= idle_req();
        case (addr)
            REG_SW_RESET: begin
                m_sw_reset = data[0];
                if (data[0]) begin
                    reset_model_log();
                end
            end
            REG_CAM_ENABLE: m_cam_enable = data[0];
            REG_DATA_TYPE:  m_data_type = data[7:0];
            REG_FMT_SELECT: m_fmt_select = data[2:0];
            REG_LOG_STATUS: m_overflow = 1'b0;
            default: begin
            end
        endcase
    endtask

    task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
        reg_req_t r;
        int       waited;
        r      = idle_req();
        r.rd   = 1'b1;
        r.addr = addr;
        @(posedge axi4s_cam_aclk);
        req <= r;
        @(posedge axi4s_cam_aclk);
        req <= idle_req();
        waited = 0;
        @(negedge axi4s_cam_aclk);
        while (!rsp.rvalid && waited < 4) begin
            @(negedge axi4s_cam_aclk);
            waited++;
        end
        if (!rsp.rvalid) begin
            $display("read of register %0d got no response within 4 cycles", addr);
            errors++;
        end
        data = rsp.rdata;
    endtask

    task automatic expect_read(input reg_addr_e addr, input logic [31:0] expected,
                               input string what);
        logic [31:0] got;
        read_reg(addr, got);
        compare_value(got, expected, what);
    endtask

    task automatic check_outputs();
        @(negedge axi4s_cam_aclk);
        compare_value(32'(cam_enable), 32'(m_cam_enable), "cam_enable_o");
        compare_value(32'(csi_data_type), 32'(m_data_type), "csi_data_type_o");
        compare_value(32'(fmt_select), 32'(m_fmt_select), "fmt_select_o");
    endtask

    task automatic drive_beat(input logic valid, input logic fs, input logic le);
        video_beat_t b;
        b.valid       = valid;
        b.frame_start = fs;
        b.line_end    = le;
        b.pixel       = RAW_BITS'($random(seed));
        @(posedge axi4s_cam_aclk);
        beat <= b;
        if (valid) begin
            model_beat(fs, le);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_beat(1'b0, 1'b0, 1'b0);
    endtask

    // invalid gap beats carry random flags that must be ignored
    task automatic send_line(input logic with_fs, input int beats, input int max_gap);
        int gap;
        for (int i = 0; i < beats; i++) begin
            gap = rand_range(0, max_gap);
            repeat (gap) begin
                drive_beat(1'b0, rand_range(0, 1) == 1, rand_range(0, 1) == 1);
            end
            drive_beat(1'b1, with_fs && i == 0, i == beats - 1);
        end
    endtask

    task automatic drain_log(input string what);
        log_entry_t e;
        expect_read(REG_LOG_STATUS, status_expected(), {what, " status"});
        while (model_q.size() > 0) begin
            e = model_q.pop_front();
            expect_read(REG_LOG_DATA, {1'b1, 7'd0, e}, {what, " entry"});
        end
        expect_read(REG_LOG_DATA, 32'd0, {what, " empty read"});
    endtask

    // --------------------
    // tests
    // --------------------

    initial begin
        int n_lines;
        sys_reset     = 1'b1;
        beat          = '0;
        req           = idle_req();
        m_sw_reset    = 1'b0;
        m_cam_enable  = 1'b0;
        m_data_type   = DATA_TYPE_INIT;
        m_fmt_select  = '0;
        reset_model_log();
        repeat (2) @(posedge axi4s_cam_aclk);
        sys_reset <= 1'b0;

        // reset values
        for (int a = 0; a < 6; a++) begin
            expect_read(reg_addr_e'(a[2:0]), expected_reg(reg_addr_e'(a[2:0])), "reset value");
        end
        check_outputs();

        // random register writes
        for (int round = 0; round < 4; round++) begin
            foreach (ctrl_addrs[i]) begin
                write_reg(ctrl_addrs[i], $random(seed));
            end
            check_outputs();
            foreach (ctrl_addrs[i]) begin
                expect_read(ctrl_addrs[i], expected_reg(ctrl_addrs[i]), "control register");
            end
        end
        write_reg(REG_ID, $random(seed));
        expect_read(REG_ID, ID_VALUE, "ID after write");
        expect_read(reg_addr_e'(3'd7), 32'd0, "unused address");
        write_reg(REG_SW_RESET, 32'd0);

        // random frames drained one at a time
        for (int f = 0; f < NUM_FRAMES; f++) begin
            n_lines = rand_range(1, 6);
            for (int l = 0; l < n_lines; l++) begin
                send_line(l == 0, rand_range(1, 8), 2);
            end
            idle_cycles(4);
            drain_log("frame");
        end

        // more lines than entries without reads in between
        for (int l = 0; l < LOG_DEPTH + 4; l++) begin
            send_line(l == 0, 3, 0);
        end
        idle_cycles(4);
        drain_log("overflow");
        write_reg(REG_LOG_STATUS, 32'd0);
        expect_read(REG_LOG_STATUS, status_expected(), "status after clear");

        // software reset holds the logger idle
        write_reg(REG_SW_RESET, 32'd1);
        send_line(1'b1, 4, 1);
        send_line(1'b0, 3, 1);
        idle_cycles(4);
        expect_read(REG_LOG_STATUS, status_expected(), "status in software reset");
        write_reg(REG_SW_RESET, 32'd0);
        send_line(1'b0, 2, 1);
        send_line(1'b1, 3, 1);
        idle_cycles(4);
        drain_log("after software reset");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(STIM_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

//--- tb/cam_line_logger_asserts.sv
module cam_line_logger_asserts
    import cam_log_pkg::*;
(
    input logic                      axi4s_cam_aclk,
    input logic                      sys_reset,
    input reg_req_t                  req_i,
    input reg_rsp_t                  rsp_i,
    input logic [LOG_COUNT_BITS-1:0] count_i,
    input logic                      overflow_i,
    input logic                      clear_overflow_i,
    input logic                      sw_reset_i
);

    // --------------------
    // log buffer
    // --------------------

    count_in_range_a: assert property (@(posedge axi4s_cam_aclk) disable iff (sys_reset)
        count_i <= LOG_COUNT_BITS'(LOG_DEPTH))
        else $error("log occupancy above depth");

    // sticky until a status write or software reset
    overflow_sticky_a: assert property (@(posedge axi4s_cam_aclk) disable iff (sys_reset)
        overflow_i && !clear_overflow_i && !sw_reset_i |=> overflow_i)
        else $error("overflow dropped without a clear");

    // --------------------
    // read timing
    // --------------------

    read_latency_a: assert property (@(posedge axi4s_cam_aclk) disable iff (sys_reset)
        req_i.rd |=> rsp_i.rvalid)
        else $error("no rvalid one cycle after a read strobe");

endmodule

bind cam_ctrl_regs cam_line_logger_asserts u_asserts (
    .axi4s_cam_aclk   (axi4s_cam_aclk),
    .sys_reset        (sys_reset),
    .req_i            (req_i),
    .rsp_i            (rsp_o),
    .count_i          (count_i),
    .overflow_i       (overflow_i),
    .clear_overflow_i (clear_overflow_o),
    .sw_reset_i       (sw_reset_o)
);

//--- design/cam_line_logger.sv
module cam_line_logger
    import cam_log_pkg::*;
(
    input  logic        axi4s_cam_aclk,
    input  logic        sys_reset,
    input  video_beat_t beat_i,
    input  reg_req_t    req_i,
    output reg_rsp_t    rsp_o,
    output logic        cam_enable_o,
    output logic [7:0]  csi_data_type_o,
    output logic [2:0]  fmt_select_o
);

    // producer to buffer
    log_entry_t entry;
    logic       push;

    // buffer to consumer
    log_entry_t                head;
    logic [LOG_COUNT_BITS-1:0] count;
    logic                      empty;
    logic                      overflow;

    // consumer back to buffer and producer
    logic pop;
    logic clear_overflow;
    logic sw_reset;

    // --------------------
    // line logger
    // --------------------

    line_event_counter u_line_event_counter (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .sw_reset_i     (sw_reset),
        .beat_i         (beat_i),
        .entry_o        (entry),
        .push_o         (push)
    );

    log_fifo u_log_fifo (
        .axi4s_cam_aclk   (axi4s_cam_aclk),
        .sys_reset        (sys_reset),
        .sw_reset_i       (sw_reset),
        .entry_i          (entry),
        .push_i           (push),
        .pop_i            (pop),
        .clear_overflow_i (clear_overflow),
        .head_o           (head),
        .count_o          (count),
        .empty_o          (empty),
        .overflow_o       (overflow)
    );

    // --------------------
    // register file
    // --------------------

    cam_ctrl_regs u_cam_ctrl_regs (
        .axi4s_cam_aclk   (axi4s_cam_aclk),
        .sys_reset        (sys_reset),
        .req_i            (req_i),
        .rsp_o            (rsp_o),
        .head_i           (head),
        .count_i          (count),
        .empty_i          (empty),
        .overflow_i       (overflow),
        .pop_o            (pop),
        .clear_overflow_o (clear_overflow),
        .sw_reset_o       (sw_reset),
        .cam_enable_o     (cam_enable_o),
        .csi_data_type_o  (csi_data_type_o),
        .fmt_select_o     (fmt_select_o)
    );

endmodule

//--- design/cam_ctrl_regs.sv
module cam_ctrl_regs
    import cam_log_pkg::*;
(
    input  logic                      axi4s_cam_aclk,
    input  logic                      sys_reset,
    input  reg_req_t                  req_i,
    output reg_rsp_t                  rsp_o,
    input  log_entry_t                head_i,
    input  logic [LOG_COUNT_BITS-1:0] count_i,
    input  logic                      empty_i,
    input  logic                      overflow_i,
    output logic                      pop_o,
    output logic                      clear_overflow_o,
    output logic                      sw_reset_o,
    output logic                      cam_enable_o,
    output logic [7:0]                csi_data_type_o,
    output logic [2:0]                fmt_select_o
);

    // --------------------
    // control registers
    // --------------------

    logic       reg_sw_reset;
    logic       reg_cam_enable;
    logic [7:0] reg_csi_data_type;
    logic [2:0] reg_fmt_select;

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_sw_reset      <= 1'b0;
            reg_cam_enable    <= 1'b0;
            reg_csi_data_type <= DATA_TYPE_INIT;
            reg_fmt_select    <= '0;
        end else if (req_i.wr) begin
            // writes are cut down to each register's width
            case (req_i.addr)
                REG_SW_RESET:   reg_sw_reset      <= req_i.wdata[0];
                REG_CAM_ENABLE: reg_cam_enable    <= req_i.wdata[0];
                REG_DATA_TYPE:  reg_csi_data_type <= req_i.wdata[7:0];
                REG_FMT_SELECT: reg_fmt_select    <= req_i.wdata[2:0];
                default: begin
                end
            endcase
        end
    end

    assign sw_reset_o      = reg_sw_reset;
    assign cam_enable_o    = reg_cam_enable;
    assign csi_data_type_o = reg_csi_data_type;
    assign fmt_select_o    = reg_fmt_select;

    // --------------------
    // log side strobes
    // --------------------

    // reading the data word pops the head, never on an empty log
    assign pop_o = req_i.rd && (req_i.addr == REG_LOG_DATA) && !empty_i;

    // any write to status clears overflow
    assign clear_overflow_o = req_i.wr && (req_i.addr == REG_LOG_STATUS);

    // --------------------
    // read mux
    // --------------------

    logic [REG_DATA_BITS-1:0] status_word;
    logic [REG_DATA_BITS-1:0] data_word;
    logic [REG_DATA_BITS-1:0] rd_word;

    always_comb begin
        status_word                     = '0;
        status_word[LOG_COUNT_BITS-1:0] = count_i;
        status_word[8]                  = empty_i;
        status_word[16]                 = overflow_i;
    end

    always_comb begin
        data_word = '0;
        if (!empty_i) begin
            data_word[$bits(log_entry_t)-1:0] = head_i;
            // marks a real entry
            data_word[31]                     = 1'b1;
        end
    end

    always_comb begin
        case (req_i.addr)
            REG_ID:         rd_word = ID_VALUE;
            REG_SW_RESET:   rd_word = REG_DATA_BITS'(reg_sw_reset);
            REG_CAM_ENABLE: rd_word = REG_DATA_BITS'(reg_cam_enable);
            REG_DATA_TYPE:  rd_word = REG_DATA_BITS'(reg_csi_data_type);
            REG_FMT_SELECT: rd_word = REG_DATA_BITS'(reg_fmt_select);
            REG_LOG_STATUS: rd_word = status_word;
            REG_LOG_DATA:   rd_word = data_word;
            default:        rd_word = '0;
        endcase
    end

    // --------------------
    // response, one cycle after rd
    // --------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            rsp_o.rvalid <= 1'b0;
        end else begin
            rsp_o.rvalid <= req_i.rd;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (req_i.rd) begin
            rsp_o.rdata <= rd_word;
        end else begin
            rsp_o.rdata <= '0;
        end
    end

endmodule

//--- design/log_fifo.sv
module log_fifo
    import cam_log_pkg::*;
(
    input  logic                      axi4s_cam_aclk,
    input  logic                      sys_reset,
    input  logic                      sw_reset_i,
    input  log_entry_t                entry_i,
    input  logic                      push_i,
    input  logic                      pop_i,
    input  logic                      clear_overflow_i,
    output log_entry_t                head_o,
    output logic [LOG_COUNT_BITS-1:0] count_o,
    output logic                      empty_o,
    output logic                      overflow_o
);

    log_entry_t                mem [LOG_DEPTH];
    logic [LOG_PTR_BITS-1:0]   wr_ptr;
    logic [LOG_PTR_BITS-1:0]   rd_ptr;
    logic [LOG_COUNT_BITS-1:0] count;
    logic                      overflow;

    logic full;
    logic do_push;
    logic do_pop;
    logic drop;

    assign full    = (count == LOG_COUNT_BITS'(LOG_DEPTH));
    assign do_pop  = pop_i && (count != '0);
    // a pop in the same cycle makes room for the push
    assign do_push = push_i && (!full || do_pop);
    assign drop    = push_i && !do_push;

    // --------------------
    // storage
    // --------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    // --------------------
    // pointers and flags
    // --------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || sw_reset_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // sticky, a drop in the clearing cycle still wins
            if (clear_overflow_i) begin
                overflow <= 1'b0;
            end
            if (drop) begin
                overflow <= 1'b1;
            end
        end
    end

    assign head_o     = mem[rd_ptr];
    assign count_o    = count;
    assign empty_o    = (count == '0);
    assign overflow_o = overflow;

endmodule

//--- design/line_event_counter.sv
module line_event_counter
    import cam_log_pkg::*;
(
    input  logic        axi4s_cam_aclk,
    input  logic        sys_reset,
    input  logic        sw_reset_i,
    input  video_beat_t beat_i,
    output log_entry_t  entry_o,
    output logic        push_o
);

    // --------------------
    // line and frame state
    // --------------------

    // high when the next valid beat opens a line
    logic                        first_beat;
    logic [LINE_COUNT_BITS-1:0]  line_index;
    logic [FRAME_COUNT_BITS-1:0] frame_count;

    logic                        line_start;
    logic                        frame_beat;
    logic [LINE_COUNT_BITS-1:0]  line_index_next;
    logic [FRAME_COUNT_BITS-1:0] frame_count_next;

    assign line_start = beat_i.valid && first_beat;
    assign frame_beat = beat_i.valid && beat_i.frame_start;

    always_comb begin
        line_index_next  = line_index;
        frame_count_next = frame_count;

        // entry made on a frame start already carries the new count
        if (frame_beat) begin
            frame_count_next = frame_count + 1'b1;
        end

        if (line_start) begin
            if (beat_i.frame_start) begin
                line_index_next = '0;
            end else begin
                line_index_next = line_index + 1'b1;
            end
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || sw_reset_i) begin
            first_beat  <= 1'b1;
            line_index  <= '0;
            frame_count <= '0;
        end else begin
            if (beat_i.valid) begin
                first_beat <= beat_i.line_end;
            end
            line_index  <= line_index_next;
            frame_count <= frame_count_next;
        end
    end

    // --------------------
    // entry output
    // --------------------

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || sw_reset_i) begin
            push_o <= 1'b0;
        end else begin
            push_o <= line_start;
        end
    end

    // payload only, qualified by push_o
    always_ff @(posedge axi4s_cam_aclk) begin
        if (line_start) begin
            entry_o.frame_count <= frame_count_next;
            entry_o.line_index  <= line_index_next;
        end
    end

endmodule

//--- design/cam_log_pkg.sv
package cam_log_pkg;

    // --------------------
    // sizes
    // --------------------

    // pixel width of the camera stream
    localparam int RAW_BITS = 10;

    // log entry fields
    localparam int LINE_COUNT_BITS  = 16;
    localparam int FRAME_COUNT_BITS = 8;

    // register bus
    localparam int REG_ADDR_BITS = 3;
    localparam int REG_DATA_BITS = 32;

    // log buffer
    localparam int LOG_DEPTH      = 16;
    localparam int LOG_PTR_BITS   = 4;
    localparam int LOG_COUNT_BITS = 5;

    // --------------------
    // register contents
    // --------------------

    localparam logic [REG_DATA_BITS-1:0] ID_VALUE       = 32'h0123_4567;
    // RAW10 per CSI-2
    localparam logic [7:0]               DATA_TYPE_INIT = 8'h2b;

    // word addresses on the register bus
    typedef enum logic [REG_ADDR_BITS-1:0] {
        REG_ID         = 3'd0,
        REG_SW_RESET   = 3'd1,
        REG_CAM_ENABLE = 3'd2,
        REG_DATA_TYPE  = 3'd3,
        REG_FMT_SELECT = 3'd4,
        REG_LOG_STATUS = 3'd5,
        REG_LOG_DATA   = 3'd6
    } reg_addr_e;

    // --------------------
    // bundles
    // --------------------

    // one beat of the pixel stream, no ready
    typedef struct packed {
        logic                valid;
        logic                frame_start;
        logic                line_end;
        logic [RAW_BITS-1:0] pixel;
    } video_beat_t;

    typedef struct packed {
        logic [FRAME_COUNT_BITS-1:0] frame_count;
        logic [LINE_COUNT_BITS-1:0]  line_index;
    } log_entry_t;

    // wr and rd are single-cycle strobes
    typedef struct packed {
        logic                     wr;
        logic                     rd;
        reg_addr_e                addr;
        logic [REG_DATA_BITS-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic                     rvalid;
        logic [REG_DATA_BITS-1:0] rdata;
    } reg_rsp_t;

endpackage
